// ==== asi_settings.svh ====
`ifndef ASI_SETTINGS_SVH
`define ASI_SETTINGS_SVH

//////////////////////////////////////////////////
// Buffering between ingress and line
//////////////////////////////////////////////////

// Symbol entries in the FIFO
`define ASI_FIFO_DEPTH 16

//////////////////////////////////////////////////
// MPEG transport stream framing
//////////////////////////////////////////////////

// Bytes per transport packet
`define ASI_TS_PACKET_LEN 188

// Value of the first byte of every packet
`define ASI_TS_SYNC 8'h47

`endif

// ==== asi_stream_pkg.sv ====
package asi_stream_pkg;

	//////////////////////////////////////////////////
	// Symbol stream payload
	//////////////////////////////////////////////////

	// One line symbol before encoding
	// kchar set means a control character
	// Data bytes from the transport stream always have kchar clear
	typedef struct packed {
		logic       kchar;
		logic [7:0] data;
	} asi_sym_t;

	// Width of one symbol, as stored in the FIFO
	localparam int unsigned ASI_SYM_W = $bits(asi_sym_t);

	// Number of bits of the plain data byte
	localparam int unsigned ASI_DATA_W = 8;

endpackage

// ==== asi_code_pkg.sv ====
package asi_code_pkg;

	import asi_stream_pkg::*;

	//////////////////////////////////////////////////
	// 8b10b line code
	//////////////////////////////////////////////////

	// Encoded group, bit a in bit 0 and bit j in bit 9
	// Bits leave the serializer from bit 0 upward
	typedef logic [9:0] code10_t;

	// Running disparity
	typedef enum logic {
		RD_NEG = 1'b0,
		RD_POS = 1'b1
	} rd_t;

	//////////////////////////////////////////////////
	// Comma character
	//////////////////////////////////////////////////

	// K28.5 as an unencoded symbol, sent when there is no data
	localparam asi_sym_t K28_5 = '{kchar: 1'b1, data: 8'hBC};

	// K28.5 code groups
	// a..j = 0011111010 for negative disparity
	localparam code10_t COMMA_RD_NEG = 10'b01_0111_1100;

	// a..j = 1100000101 for positive disparity
	localparam code10_t COMMA_RD_POS = 10'b10_1000_0011;

endpackage

// ==== asi_stream_if.sv ====
interface asi_stream_if
	import asi_stream_pkg::*;
();

	// Handshake pair
	logic     valid;
	logic     ready;

	// Payload
	asi_sym_t sym;

	// First byte of a transport packet
	logic     sop;

	// Side that offers symbols
	modport producer (output valid, output sym, output sop, input ready);

	// Side that takes symbols
	// Item moves on every edge with valid and ready high
	modport consumer (input valid, input sym, input sop, output ready);

endinterface

// ==== ts_ingress.sv ====
`include "asi_settings.svh"

module ts_ingress
	import asi_stream_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           ts_valid,
	output logic           ts_ready,
	input  logic [7:0]     ts_data,
	output logic           sync_err,
	asi_stream_if.producer out
);

	localparam int unsigned POS_W = $clog2(`ASI_TS_PACKET_LEN);
	localparam logic [POS_W-1:0] POS_LAST = POS_W'(`ASI_TS_PACKET_LEN - 1);
	localparam logic [7:0] SYNC = `ASI_TS_SYNC;

	// Byte position inside the current packet
	logic [POS_W-1:0] pos;
	// Framing found, position is trusted
	logic             locked;
	// Previous packet start was already bad
	logic             miss;
	logic             accept;
	logic             is_sync;

	//////////////////////////////////////////////////
	// Byte path, straight to the FIFO
	//////////////////////////////////////////////////

	assign accept   = ts_valid && out.ready;
	assign is_sync  = (ts_data == SYNC);
	assign ts_ready = out.ready;
	assign out.valid = ts_valid;
	assign out.sym   = asi_sym_t'{kchar: 1'b0, data: ts_data};
	// Packet start by count when locked, by sync byte when hunting
	assign out.sop   = locked ? (pos == '0) : is_sync;

	//////////////////////////////////////////////////
	// Framing tracker
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos      <= '0;
			locked   <= 1'b0;
			miss     <= 1'b0;
			sync_err <= 1'b0;
		end else begin
			// One cycle pulse per bad packet start
			sync_err <= accept && locked && (pos == '0) && !is_sync;
			if (accept) begin
				if (!locked) begin
					// Hunting, restart the count at the sync byte
					if (is_sync) begin
						pos    <= POS_W'(1);
						locked <= 1'b1;
						miss   <= 1'b0;
					end
				end else begin
					pos <= (pos == POS_LAST) ? '0 : pos + 1'b1;
					if (pos == '0) begin
						if (is_sync) begin
							miss <= 1'b0;
						end else if (miss) begin
							// Two bad starts in a row, go hunting
							locked <= 1'b0;
						end else begin
							miss <= 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

// ==== asi_fifo.sv ====
`include "asi_settings.svh"

module asi_fifo
	import asi_stream_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	asi_stream_if.consumer wr,
	asi_stream_if.producer rd
);

	localparam int unsigned DEPTH = `ASI_FIFO_DEPTH;
	localparam int unsigned PTR_W = $clog2(DEPTH);
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	// Storage, symbol and packet start side by side
	asi_sym_t         mem_sym [DEPTH];
	logic             mem_sop [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	logic             push;
	logic             pop;
	// Room for one more word
	logic             ready_q;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push     = wr.valid && ready_q;
	assign pop      = rd.valid && rd.ready;
	assign wr.ready = ready_q;

	// Read side shows the head word
	assign rd.valid = (count != '0);
	assign rd.sym   = mem_sym[rd_ptr];
	assign rd.sop   = mem_sop[rd_ptr];

	always_comb begin
		count_nxt = count;
		if (push && !pop) begin
			count_nxt = count + 1'b1;
		end else if (pop && !push) begin
			count_nxt = count - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and fill level
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			ready_q <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count   <= count_nxt;
			// Back-pressure once every entry is taken
			ready_q <= (count_nxt != CNT_W'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_sym[wr_ptr] <= wr.sym;
			mem_sop[wr_ptr] <= wr.sop;
		end
	end

endmodule

// ==== asi_8b10b_encoder.sv ====
module asi_8b10b_encoder
	import asi_stream_pkg::*;
	import asi_code_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  asi_sym_t sym,
	output code10_t  code
);

	// 5b6b groups for negative disparity, written abcdei, index EDCBA
	localparam logic [5:0] TBL_5B6B [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001,
		6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100,
		6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010,
		6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011
	};

	// 3b4b groups for negative disparity, written fghj, index HGF
	// Entry 7 is the primary D.x.P7
	localparam logic [3:0] TBL_3B4B [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100,
		4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	rd_t        rd;
	rd_t        rd_mid;
	rd_t        rd_nxt;
	logic [4:0] x5;
	logic [2:0] y3;
	logic [5:0] blk6;
	logic [3:0] blk4;
	logic       alt7;
	code10_t    code_nxt;

	assign x5 = sym.data[4:0];
	assign y3 = sym.data[7:5];

	always_comb begin
		//////////////////////////////////////////////////
		// 5b6b sub-block
		//////////////////////////////////////////////////
		blk6   = TBL_5B6B[x5];
		rd_mid = rd;
		if ($countones(TBL_5B6B[x5]) != 3) begin
			if (rd == RD_POS) blk6 = ~blk6;
			rd_mid = rd_t'(~rd);
		end else if ((x5 == 5'd7) && (rd == RD_POS)) begin
			blk6 = ~blk6;
		end
		//////////////////////////////////////////////////
		// 3b4b sub-block
		//////////////////////////////////////////////////
		// A7 avoids a run of five equal bits
		alt7 = (rd_mid == RD_NEG) ? (x5 inside {5'd17, 5'd18, 5'd20}) :
		                            (x5 inside {5'd11, 5'd13, 5'd14});
		blk4   = ((y3 == 3'd7) && alt7) ? 4'b0111 : TBL_3B4B[y3];
		rd_nxt = rd_mid;
		if ($countones(blk4) != 2) begin
			if (rd_mid == RD_POS) blk4 = ~blk4;
			rd_nxt = rd_t'(~rd_mid);
		end else if ((y3 == 3'd3) && (rd_mid == RD_POS)) begin
			blk4 = ~blk4;
		end
		// Bit a to bit 0
		for (int k = 0; k < 6; k++) code_nxt[k] = blk6[5-k];
		for (int k = 0; k < 4; k++) code_nxt[6+k] = blk4[3-k];
		// Any control character goes out as K28.5, which flips disparity
		if (sym.kchar) begin
			code_nxt = (rd == RD_NEG) ? COMMA_RD_NEG : COMMA_RD_POS;
			rd_nxt   = rd_t'(~rd);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			code <= '0;
			rd   <= RD_NEG;
		end else if (load) begin
			code <= code_nxt;
			rd   <= rd_nxt;
		end
	end

endmodule

// ==== asi_line_tx.sv ====
module asi_line_tx
	import asi_stream_pkg::*;
	import asi_code_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	asi_stream_if.consumer in,
	output logic           asi_out
);

	localparam logic [3:0] CNT_LAST = 4'd9;

	// Bit time inside the current symbol
	logic [3:0] bit_cnt;
	// Symbol request slot
	logic       sym_slot;
	asi_sym_t   tx_sym;
	code10_t    enc_code;
	code10_t    shreg;

	//////////////////////////////////////////////////
	// Symbol scheduler
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= (bit_cnt == CNT_LAST) ? '0 : bit_cnt + 1'b1;
		end
	end

	assign sym_slot = (bit_cnt == CNT_LAST);
	// Pop only in the request slot
	assign in.ready = sym_slot;
	// Comma fills the line when the FIFO is empty
	assign tx_sym   = in.valid ? in.sym : K28_5;

	asi_8b10b_encoder asi_8b10b_encoder_i (
		.clk  (clk),
		.rst_n(rst_n),
		.load (sym_slot),
		.sym  (tx_sym),
		.code (enc_code)
	);

	//////////////////////////////////////////////////
	// 10-to-1 serializer
	//////////////////////////////////////////////////

	// Takes the group encoded one slot earlier, bit a first
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shreg <= '0;
		end else if (sym_slot) begin
			shreg <= enc_code;
		end else begin
			shreg <= {1'b0, shreg[9:1]};
		end
	end

	assign asi_out = shreg[0];

endmodule

// ==== asi_tx_top.sv ====
module asi_tx_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ts_valid,
	output logic       ts_ready,
	input  logic [7:0] ts_data,
	output logic       asi_out,
	output logic       sync_err
);

	// Ingress to buffer
	asi_stream_if ing_to_fifo ();
	// Buffer to line
	asi_stream_if fifo_to_tx ();

	ts_ingress ts_ingress_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ts_valid(ts_valid),
		.ts_ready(ts_ready),
		.ts_data (ts_data),
		.sync_err(sync_err),
		.out     (ing_to_fifo.producer)
	);

	asi_fifo asi_fifo_i (
		.clk  (clk),
		.rst_n(rst_n),
		.wr   (ing_to_fifo.consumer),
		.rd   (fifo_to_tx.producer)
	);

	// Packet start marker stops here, the line has none
	asi_line_tx asi_line_tx_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.in     (fifo_to_tx.consumer),
		.asi_out(asi_out)
	);

endmodule

// ==== asi_rx_monitor.sv ====
module asi_rx_monitor
	import asi_code_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic asi_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// 5b6b code groups for negative disparity, written abcdei, index EDCBA
	localparam logic [5:0] DEC_6B [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001,
		6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100,
		6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010,
		6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011
	};

	// 3b4b code groups for negative disparity, written fghj, primary 7 last
	localparam logic [3:0] DEC_4B [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100,
		4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	// Receive window, newest bit on top, bit a in bit 0 once aligned
	logic [9:0]  win;
	logic [3:0]  bit_pos;
	logic        aligned;
	// Running disparity, 1 for positive
	logic        rd;
	logic        last_comma;
	logic [9:0]  last_group;
	int unsigned group_cnt = 0;
	int unsigned comma_cnt = 0;
	int unsigned err_cnt = 0;
	// Decoded data bytes, in line order
	logic [7:0]  data_q [$];

	// Result packs legal, new disparity, kchar, then HGF EDCBA
	function automatic logic [10:0] decode_group(input logic [9:0] g, input logic rd_in);
		logic [5:0] six;
		logic [3:0] four;
		logic [5:0] exp6;
		logic [3:0] exp4;
		logic [4:0] x;
		logic [2:0] y;
		logic       ok6;
		logic       ok4;
		logic       k;
		logic       rd_mid;
		logic       rd_out;
		logic       alt7;
		six    = {g[0], g[1], g[2], g[3], g[4], g[5]};
		four   = {g[6], g[7], g[8], g[9]};
		ok6    = 1'b0;
		ok4    = 1'b0;
		k      = 1'b0;
		x      = '0;
		y      = '0;
		rd_mid = rd_in;
		rd_out = rd_in;
		// Unbalanced groups and D.07 are complemented at positive disparity
		for (int v = 0; v < 32; v++) begin
			exp6 = DEC_6B[v];
			if (rd_in && (($countones(exp6) != 3) || (v == 7)))
				exp6 = ~exp6;
			if (six == exp6) begin
				ok6    = 1'b1;
				x      = 5'(v);
				rd_mid = ($countones(exp6) == 3) ? rd_in : !rd_in;
			end
		end
		// K28 only exists as a control group
		exp6 = rd_in ? 6'b110000 : 6'b001111;
		if (six == exp6) begin
			ok6    = 1'b1;
			k      = 1'b1;
			x      = 5'd28;
			rd_mid = !rd_in;
		end
		alt7 = rd_mid ? (x inside {5'd11, 5'd13, 5'd14}) : (x inside {5'd17, 5'd18, 5'd20});
		if (k) begin
			// Only K28.5 is legal here, with its own fghj
			ok4    = (four == (rd_in ? 4'b0101 : 4'b1010));
			y      = 3'd5;
			rd_out = !rd_in;
		end else begin
			for (int w = 0; w < 8; w++) begin
				exp4 = DEC_4B[w];
				if (rd_mid && (($countones(exp4) != 2) || (w == 3)))
					exp4 = ~exp4;
				if ((four == exp4) && !((w == 7) && alt7)) begin
					ok4    = 1'b1;
					y      = 3'(w);
					rd_out = ($countones(exp4) == 2) ? rd_mid : !rd_mid;
				end
			end
			// A7 replaces P7 where a run of five would appear
			exp4 = rd_mid ? 4'b1000 : 4'b0111;
			if ((four == exp4) && alt7) begin
				ok4    = 1'b1;
				y      = 3'd7;
				rd_out = !rd_mid;
			end
		end
		return {ok6 && ok4, rd_out, k, y, x};
	endfunction

	task automatic take_group();
		logic [10:0] dec;
		dec = decode_group(win, rd);
		group_cnt++;
		assert ($countones(win) inside {4, 5, 6}) else begin
			$display("CHECK FAILED rx_group ones: group 0x%03h has 0x%0h ones", win,
				$countones(win));
			err_cnt++;
		end
		assert (dec[10]) else begin
			$display("CHECK FAILED rx_group: 0x%03h not legal at disparity 0x%0h", win, rd);
			err_cnt++;
		end
		// Idle commas swap code group every time
		if (last_comma && ((win == COMMA_RD_NEG) || (win == COMMA_RD_POS))) begin
			assert (win != last_group) else begin
				$display("CHECK FAILED comma: 0x%03h repeated, expected 0x%03h",
					win, ~win);
				err_cnt++;
			end
		end
		if (dec[10]) begin
			rd = dec[9];
			if (dec[8]) begin
				comma_cnt++;
			end else begin
				data_q.push_back(dec[7:0]);
			end
			last_comma = dec[8];
			last_group = win;
		end else begin
			// Lost the symbol boundary, hunt for the next comma
			aligned    = 1'b0;
			last_comma = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////
	// Bit sampling and comma alignment
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			win        = '0;
			bit_pos    = '0;
			aligned    = 1'b0;
			rd         = 1'b0;
			last_comma = 1'b0;
			last_group = '0;
		end else begin
			win = {asi_out, win[9:1]};
			if (!aligned) begin
				if ((win == COMMA_RD_NEG) || (win == COMMA_RD_POS)) begin
					// Line starts at negative disparity
					if (group_cnt == 0) begin
						assert (win == COMMA_RD_NEG) else begin
							$display("CHECK FAILED first comma: got 0x%03h expected 0x%03h",
								win, COMMA_RD_NEG);
							err_cnt++;
						end
					end
					aligned    = 1'b1;
					bit_pos    = '0;
					rd         = (win == COMMA_RD_NEG);
					last_comma = 1'b1;
					last_group = win;
					group_cnt++;
					comma_cnt++;
				end
			end else begin
				bit_pos++;
				if (bit_pos == 4'd10) begin
					bit_pos = '0;
					take_group();
				end
			end
		end
	end

endmodule

// ==== tb_asi_tx.sv ====
`include "asi_settings.svh"

module tb_asi_tx;

	timeunit 1ns;
	timeprecision 100ps;

	// Whole run takes about 12000 cycles, ten line cycles per byte
	localparam int unsigned TIMEOUT_CYCLES = 20000;
	localparam logic [7:0] SYNC = `ASI_TS_SYNC;
	localparam int unsigned PKT_LEN = `ASI_TS_PACKET_LEN;
	localparam int unsigned BURST_LEN = 40;

	logic        clk;
	logic        rst_n;
	logic        ts_valid;
	logic        ts_ready;
	logic [7:0]  ts_data;
	logic        asi_out;
	logic        sync_err;

	integer      seed;
	int unsigned cycle_cnt = 0;
	int unsigned err_cnt = 0;
	int unsigned sync_err_cnt = 0;
	int unsigned test_pass = 0;
	int unsigned test_fail = 0;
	logic        saw_stall;
	logic [7:0]  exp_q [$];

	asi_tx_top asi_tx_top_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ts_valid(ts_valid),
		.ts_ready(ts_ready),
		.ts_data (ts_data),
		.asi_out (asi_out),
		.sync_err(sync_err)
	);

	asi_rx_monitor asi_rx_monitor_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.asi_out(asi_out)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// Watchdog and protocol checks
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// Pulses are one cycle wide, so each is seen once here
	always @(negedge clk) begin
		if (rst_n && sync_err)
			sync_err_cnt++;
	end

	sync_err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		sync_err |=> !sync_err)
	else begin
		$display("sync_err stayed high for more than one cycle");
		err_cnt++;
	end

	ready_low_in_reset: assert property (@(posedge clk) !rst_n |=> !ts_ready)
	else begin
		$display("CHECK FAILED ts_ready: got 0x%0h expected 0x0", ts_ready);
		err_cnt++;
	end

	function automatic int unsigned total_errors();
		return err_cnt + asi_rx_monitor_i.err_cnt;
	endfunction

	// Entered just after a rising edge, leaves just after the accepting edge
	task automatic send_byte(input logic [7:0] b);
		logic accepted;
		ts_valid = 1'b1;
		ts_data  = b;
		exp_q.push_back(b);
		do begin
			@(negedge clk);
			if (!ts_ready)
				saw_stall = 1'b1;
			accepted = ts_ready;
			@(posedge clk);
			#1;
		end while (!accepted);
	endtask

	task automatic send_packet(input logic [7:0] first);
		logic [7:0] b;
		send_byte(first);
		for (int i = 1; i < PKT_LEN; i++) begin
			b = 8'($random(seed));
			send_byte(b);
		end
	endtask

	// Compare every expected byte against the line, in order
	task automatic check_rx();
		logic [7:0] got;
		logic [7:0] exp;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			while ((asi_rx_monitor_i.data_q.size() != 0) && (exp_q.size() != 0)) begin
				got = asi_rx_monitor_i.data_q.pop_front();
				exp = exp_q.pop_front();
				assert (got == exp) else begin
					$display("CHECK FAILED rx_data: got 0x%02h expected 0x%02h", got, exp);
					err_cnt++;
				end
			end
		end
		@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name, input int unsigned err_before);
		if (total_errors() == err_before) begin
			test_pass++;
			$display("[%0t] %s: ok", $time, name);
		end else begin
			test_fail++;
			$display("[%0t] %s: %0d errors", $time, name, total_errors() - err_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int unsigned e0;
		int unsigned s0;
		int unsigned c0;
		logic [7:0]  b;
		seed      = 32'h46d44333;
		rst_n     = 1'b0;
		ts_valid  = 1'b0;
		ts_data   = 8'h00;
		saw_stall = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Nothing offered, line carries commas only
		e0 = total_errors();
		while (asi_rx_monitor_i.group_cnt < 12)
			@(negedge clk);
		assert (asi_rx_monitor_i.data_q.size() == 0) else begin
			$display("CHECK FAILED rx data count: got 0x%0h expected 0x0",
				asi_rx_monitor_i.data_q.size());
			err_cnt++;
		end
		assert (asi_rx_monitor_i.comma_cnt == asi_rx_monitor_i.group_cnt) else begin
			$display("CHECK FAILED comma_cnt: got 0x%0h expected 0x%0h",
				asi_rx_monitor_i.comma_cnt, asi_rx_monitor_i.group_cnt);
			err_cnt++;
		end
		@(posedge clk);
		#1;
		end_test("idle line", e0);

		// Two framed packets with random payload
		e0 = total_errors();
		s0 = sync_err_cnt;
		send_packet(SYNC);
		send_packet(SYNC);
		ts_valid = 1'b0;
		check_rx();
		assert (sync_err_cnt == s0) else begin
			$display("CHECK FAILED sync_err pulses: got 0x%0h expected 0x0", sync_err_cnt - s0);
			err_cnt++;
		end
		end_test("data integrity", e0);

		// Counting payload, every byte value goes through the encoder
		e0 = total_errors();
		for (int p = 0; p < 2; p++) begin
			send_byte(SYNC);
			for (int k = 0; k < PKT_LEN - 1; k++) begin
				b = 8'(p * (PKT_LEN - 1) + k);
				send_byte(b);
			end
		end
		ts_valid = 1'b0;
		check_rx();
		end_test("running disparity", e0);

		// Bad packet start, then a good packet
		e0 = total_errors();
		s0 = sync_err_cnt;
		send_packet(8'h00);
		send_packet(SYNC);
		ts_valid = 1'b0;
		check_rx();
		assert ((sync_err_cnt - s0) == 1) else begin
			$display("CHECK FAILED sync_err pulses: got 0x%0h expected 0x1", sync_err_cnt - s0);
			err_cnt++;
		end
		end_test("packet framing", e0);

		// Burst faster than the line, FIFO must fill
		e0 = total_errors();
		saw_stall = 1'b0;
		c0 = 0;
		fork
			begin
				send_byte(SYNC);
				for (int i = 1; i < BURST_LEN; i++) begin
					b = 8'($random(seed));
					send_byte(b);
				end
				ts_valid = 1'b0;
			end
			begin
				while (asi_rx_monitor_i.data_q.size() == 0)
					@(negedge clk);
				c0 = asi_rx_monitor_i.comma_cnt;
			end
		join
		while (asi_rx_monitor_i.data_q.size() < BURST_LEN)
			@(negedge clk);
		assert (asi_rx_monitor_i.comma_cnt == c0) else begin
			$display("CHECK FAILED comma_cnt during burst: got 0x%0h expected 0x%0h",
				asi_rx_monitor_i.comma_cnt, c0);
			err_cnt++;
		end
		assert (saw_stall) else begin
			$display("ts_ready never dropped while the burst was offered");
			err_cnt++;
		end
		check_rx();
		end_test("back-pressure", e0);

		$display("Tests: %0d passed, %0d failed, %0d check errors",
			test_pass, test_fail, total_errors());
		if ((test_fail == 0) && (total_errors() == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
asi_stream_pkg.sv
asi_code_pkg.sv
asi_stream_if.sv
ts_ingress.sv
asi_fifo.sv
asi_8b10b_encoder.sv
asi_line_tx.sv
asi_tx_top.sv
asi_rx_monitor.sv
tb_asi_tx.sv

// ==== Bender.yml ====
package:
  name: asi_tx

export_include_dirs:
  - .

sources:
  - asi_stream_pkg.sv
  - asi_code_pkg.sv
  - asi_stream_if.sv
  - ts_ingress.sv
  - asi_fifo.sv
  - asi_8b10b_encoder.sv
  - asi_line_tx.sv
  - asi_tx_top.sv
  - target: test
    files:
      - asi_rx_monitor.sv
      - tb_asi_tx.sv
